// ==== all.f ====
hdl/sram_ctrl_pkg.sv
hdl/sram_read_seq.sv
hdl/sram_write_seq.sv
hdl/sram_bus_arbiter.sv
hdl/sram_apb_ctrl.sv
verification/sram_async_model.sv
verification/tb_sram_apb_ctrl.sv

// ==== Makefile ====
# Verilator build and run for the APB SRAM controller

VERILATOR ?= verilator
TOP       ?= tb_sram_apb_ctrl
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/1ns
VFLAGS    ?= --binary --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert
PASS_MSG  := TEST OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		-f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verification/tb_sram_apb_ctrl.sv ====
`timescale 1ns/1ns

module tb_sram_apb_ctrl;

  localparam int ADDR_BITS  = 10;
  localparam int DATA_BITS  = 16;
  localparam int T_AA_CYC   = 3;
  localparam int T_AW_CYC   = 2;
  localparam int NUM_VEC    = 17;
  localparam int MAX_CYCLES = NUM_VEC * (T_AA_CYC + T_AW_CYC + 8) + 50;
  localparam logic [DATA_BITS-1:0] POISON   = {(DATA_BITS/2){2'b10}};
  localparam logic [31:0]          TOP_ADDR = (32'd1 << ADDR_BITS) - 32'd1;

  // One table row, the name lives in a separate array
  typedef struct packed {
    logic                 write;
    logic [31:0]          addr;
    logic [DATA_BITS-1:0] wdata;
    logic [DATA_BITS-1:0] exp_rdata;
    logic                 exp_err;
  } vec_t;

  logic                      oe_n;
  logic                      rst_n;
  logic                      psel;
  logic                      penable;
  logic                      pwrite;
  logic [31:0]               paddr;
  logic [DATA_BITS-1:0]      pwdata;
  logic [DATA_BITS-1:0]      prdata;
  logic                      pready;
  logic                      pslverr;
  sram_ctrl_pkg::sram_pins_t sram;
  logic [DATA_BITS-1:0]      sram_rdata;
  sram_ctrl_pkg::sram_pins_t idle_pins;

  vec_t                 vec_tab  [NUM_VEC];
  string                vec_name [NUM_VEC];
  // Last word written to each address
  logic [DATA_BITS-1:0] shadow   [2**ADDR_BITS];
  int                   n_vec     = 0;
  int                   errors    = 0;
  int                   tests_run = 0;
  int                   cycle_cnt = 0;
  int                   seed      = 32'hff01cc32;
  string                cur_test  = "reset";

  sram_apb_ctrl #(
    .ADDR_BITS(ADDR_BITS), .DATA_BITS(DATA_BITS),
    .T_AA_CYC(T_AA_CYC), .T_AW_CYC(T_AW_CYC)
  ) dut0 (
    .oe_n(oe_n), .rst_n(rst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
    .pslverr(pslverr), .sram(sram), .sram_rdata(sram_rdata)
  );

  sram_async_model #(
    .ADDR_BITS(ADDR_BITS), .DATA_BITS(DATA_BITS),
    .T_AA_CYC(T_AA_CYC), .T_AW_CYC(T_AW_CYC)
  ) model0 (
    .oe_n(oe_n), .sram(sram), .sram_rdata(sram_rdata)
  );

  initial begin
    oe_n = 1'b0;
    forever #10 oe_n = ~oe_n;
  end

  // Watchdog sized from the table length
  always @(posedge oe_n) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout in %s: pready never came within %0d cycles", cur_test, MAX_CYCLES);
      $display("TEST FAILED");
      $finish;
    end
  end

  // Expected read word follows the last write, out of range touches nothing
  task automatic add_vec(input string name, input logic write, input logic rnd,
                         input logic [31:0] addr, input logic [DATA_BITS-1:0] data);
    vec_t v;
    v.write     = write;
    v.addr      = addr;
    v.wdata     = rnd ? DATA_BITS'($random(seed)) : data;
    v.exp_err   = (addr > TOP_ADDR);
    v.exp_rdata = '0;
    if (!v.exp_err && write) begin
      shadow[addr[ADDR_BITS-1:0]] = v.wdata;
    end else if (!v.exp_err) begin
      v.exp_rdata = shadow[addr[ADDR_BITS-1:0]];
    end
    vec_tab[n_vec]  = v;
    vec_name[n_vec] = name;
    n_vec++;
  endtask

  function automatic sram_ctrl_pkg::apb_op_t resp_op(input logic ready, input logic err,
                                                     input logic write);
    if (err) begin
      return sram_ctrl_pkg::op_error;
    end
    if (!ready) begin
      return sram_ctrl_pkg::op_none;
    end
    return write ? sram_ctrl_pkg::op_write : sram_ctrl_pkg::op_read;
  endfunction

  task automatic check_data(input string name, input logic [DATA_BITS-1:0] exp,
                            input logic [DATA_BITS-1:0] act);
    if (act !== exp) begin
      errors++;
      $display("mismatch %s: expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_resp(input string name, input sram_ctrl_pkg::apb_op_t exp,
                            input sram_ctrl_pkg::apb_op_t act);
    if (act !== exp) begin
      errors++;
      $display("mismatch %s: expected %s actual %s", name, exp.name(), act.name());
    end
  endtask

  // Strobes and bus driver only, address and data are free when idle
  task automatic check_pins(input string name, input sram_ctrl_pkg::sram_pins_t exp,
                            input sram_ctrl_pkg::sram_pins_t act);
    if ({act.ce_n, act.sram_oe_n, act.we_n, act.data_oe} !==
        {exp.ce_n, exp.sram_oe_n, exp.we_n, exp.data_oe}) begin
      errors++;
      $display("mismatch %s: expected ce/oe/we/data_oe %b%b%b%b actual %b%b%b%b", name,
               exp.ce_n, exp.sram_oe_n, exp.we_n, exp.data_oe,
               act.ce_n, act.sram_oe_n, act.we_n, act.data_oe);
    end
  endtask

  // Setup then access phase, returns in the cycle that carries pready
  task automatic apb_xfer(input logic write, input logic [31:0] addr,
                          input logic [DATA_BITS-1:0] wdata,
                          output logic [DATA_BITS-1:0] rdata, output logic err);
    @(posedge oe_n);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= write;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge oe_n);
    penable <= 1'b1;
    // Outputs sampled mid-cycle
    @(negedge oe_n);
    while (!pready) begin
      @(negedge oe_n);
    end
    rdata = prdata;
    err   = pslverr;
  endtask

  task automatic run_vec(input int i);
    logic [DATA_BITS-1:0]   rdata;
    logic                   err;
    int                     errs_before;
    sram_ctrl_pkg::apb_op_t exp_op;
    errs_before = errors;
    cur_test    = vec_name[i];
    apb_xfer(vec_tab[i].write, vec_tab[i].addr, vec_tab[i].wdata, rdata, err);
    exp_op = resp_op(1'b1, vec_tab[i].exp_err, vec_tab[i].write);
    check_resp(vec_name[i], exp_op, resp_op(1'b1, err, vec_tab[i].write));
    if (!vec_tab[i].write && !vec_tab[i].exp_err) begin
      check_data(vec_name[i], vec_tab[i].exp_rdata, rdata);
      if (rdata === POISON && vec_tab[i].exp_rdata !== POISON) begin
        errors++;
        $display("%s: read returned the access-time poison word", vec_name[i]);
      end
    end
    tests_run++;
    $display("%s %s", (errors == errs_before) ? "pass" : "fail", vec_name[i]);
  endtask

  initial begin
    rst_n   = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    idle_pins           = '0;
    idle_pins.ce_n      = 1'b1;
    idle_pins.sram_oe_n = 1'b1;
    idle_pins.we_n      = 1'b1;

    // Same address, then spread addresses read back in another order
    add_vec("wr_rd_write",  1'b1, 1'b0, 32'h005, 16'h1234);
    add_vec("wr_rd_read",   1'b0, 1'b0, 32'h005, '0);
    add_vec("multi_w0",     1'b1, 1'b0, 32'h000, 16'h0f0f);
    add_vec("multi_wtop",   1'b1, 1'b0, TOP_ADDR, 16'hf00d);
    add_vec("multi_w200",   1'b1, 1'b0, 32'h200, 16'h5a5a);
    add_vec("multi_w100",   1'b1, 1'b0, 32'h100, 16'hc3c3);
    add_vec("multi_rtop",   1'b0, 1'b0, TOP_ADDR, '0);
    add_vec("multi_r100",   1'b0, 1'b0, 32'h100, '0);
    add_vec("multi_r0",     1'b0, 1'b0, 32'h000, '0);
    add_vec("multi_r200",   1'b0, 1'b0, 32'h200, '0);
    add_vec("rand_w0",      1'b1, 1'b1, 32'h033, '0);
    add_vec("rand_r0",      1'b0, 1'b0, 32'h033, '0);
    add_vec("rand_w1",      1'b1, 1'b1, 32'h2f1, '0);
    add_vec("rand_r1",      1'b0, 1'b0, 32'h2f1, '0);
    // Low bits alias address 0, which must survive
    add_vec("range_write",  1'b1, 1'b0, 32'h400, 16'hdead);
    add_vec("range_read",   1'b0, 1'b0, 32'h0001_0000, '0);
    add_vec("range_r0",     1'b0, 1'b0, 32'h000, '0);

    repeat (4) @(posedge oe_n);
    rst_n <= 1'b1;
    @(negedge oe_n);
    check_resp("after_reset", sram_ctrl_pkg::op_none, resp_op(pready, pslverr, 1'b0));
    check_pins("after_reset", idle_pins, sram);
    tests_run++;
    $display("%s after_reset", (errors == 0) ? "pass" : "fail");

    // Back to back, no idle cycle between transfers
    for (int i = 0; i < n_vec; i++) begin
      run_vec(i);
    end
    @(posedge oe_n);
    psel    <= 1'b0;
    penable <= 1'b0;
    repeat (4) @(posedge oe_n);

    if (model0.viol_cnt != 0) begin
      errors = errors + model0.viol_cnt;
      $display("sram model saw %0d bus rule violations", model0.viol_cnt);
    end
    $display("tests run %0d, errors %0d", tests_run, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== verification/sram_async_model.sv ====
`timescale 1ns/1ns

module sram_async_model #(
  parameter int ADDR_BITS = 10,
  parameter int DATA_BITS = 16,
  parameter int T_AA_CYC  = 3,
  parameter int T_AW_CYC  = 2
) (
  input  logic                      oe_n,
  input  sram_ctrl_pkg::sram_pins_t sram,
  output logic [DATA_BITS-1:0]      sram_rdata
);

  // Alternating ones and zeros while the access time runs
  localparam logic [DATA_BITS-1:0] POISON = {(DATA_BITS/2){2'b10}};

  logic [DATA_BITS-1:0] mem [2**ADDR_BITS];
  logic [ADDR_BITS-1:0] addr;
  logic [DATA_BITS-1:0] wdata;
  int                   rd_cnt    = 0;
  int                   we_cnt    = 0;
  logic                 sel_q     = 1'b0;
  logic                 we_n_q    = 1'b1;
  logic                 data_oe_q = 1'b0;
  logic [ADDR_BITS-1:0] addr_q    = '0;
  logic [DATA_BITS-1:0] wdata_q   = '0;
  // Bus rule violations, read by the testbench at the end
  int                   viol_cnt  = 0;

  assign addr  = sram.addr[ADDR_BITS-1:0];
  assign wdata = sram.wdata[DATA_BITS-1:0];

  always @(posedge oe_n) begin
    // Access cycles since sram_oe_n fell, saturating
    if (sram.ce_n || sram.sram_oe_n) begin
      rd_cnt <= 0;
    end else if (rd_cnt < T_AA_CYC) begin
      rd_cnt <= rd_cnt + 1;
    end
    // Width of the current we_n pulse
    we_cnt <= sram.we_n ? 0 : we_cnt + 1;
    // Write lands on the rising edge of we_n
    if (!sram.ce_n && sram.we_n && !we_n_q) begin
      mem[addr] <= wdata;
    end
    sel_q     <= !sram.ce_n;
    we_n_q    <= sram.we_n;
    data_oe_q <= sram.data_oe;
    addr_q    <= addr;
    wdata_q   <= wdata;
  end

  // Word valid at the T_AA_CYC-th edge after sram_oe_n falls
  always_comb begin
    if (sram.ce_n || sram.sram_oe_n) begin
      sram_rdata = '0;
    end else if (rd_cnt >= T_AA_CYC - 1) begin
      sram_rdata = mem[addr];
    end else begin
      sram_rdata = POISON;
    end
  end

  // Address held while the chip stays selected
  a_addr_stable: assert property (@(posedge oe_n) sel_q && !sram.ce_n |-> addr == addr_q)
    else begin
      viol_cnt++;
      $display("sram model: address moved during an access");
    end

  // Data held while the controller drives the bus
  a_data_stable: assert property (@(posedge oe_n)
    data_oe_q && sram.data_oe |-> wdata == wdata_q)
    else begin
      viol_cnt++;
      $display("sram model: write data moved during a write");
    end

  // Write pulse at least T_AW_CYC cycles wide
  a_we_width: assert property (@(posedge oe_n)
    !sram.ce_n && sram.we_n && !we_n_q |-> we_cnt >= T_AW_CYC)
    else begin
      viol_cnt++;
      $display("sram model: write pulse too short (%0d cycles)", we_cnt);
    end

endmodule

// ==== hdl/sram_apb_ctrl.sv ====
`timescale 1ns/1ns

module sram_apb_ctrl #(
  parameter int ADDR_BITS = 10,
  parameter int DATA_BITS = 16,
  parameter int T_AA_CYC  = 3,
  parameter int T_AW_CYC  = 2
) (
  input  logic                      oe_n,
  input  logic                      rst_n,
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  logic [31:0]               paddr,
  input  logic [DATA_BITS-1:0]      pwdata,
  output logic [DATA_BITS-1:0]      prdata,
  output logic                      pready,
  output logic                      pslverr,
  output sram_ctrl_pkg::sram_pins_t sram,
  input  logic [DATA_BITS-1:0]      sram_rdata
);

  sram_ctrl_pkg::sram_pins_t rd_pins;
  sram_ctrl_pkg::sram_pins_t wr_pins;
  logic                      rd_start;
  logic                      wr_start;
  logic                      rd_busy;
  logic                      wr_busy;
  logic                      rd_done;
  logic                      wr_done;
  logic [DATA_BITS-1:0]      rd_data;
  logic [ADDR_BITS-1:0]      start_addr;
  logic [DATA_BITS-1:0]      start_wdata;

  // APB decode and pin selection
  sram_bus_arbiter #(
    .ADDR_BITS(ADDR_BITS),
    .DATA_BITS(DATA_BITS)
  ) arb0 (
    .oe_n(oe_n), .rst_n(rst_n),
    .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata),
    .rd_pins(rd_pins), .wr_pins(wr_pins),
    .rd_busy(rd_busy), .wr_busy(wr_busy),
    .rd_done(rd_done), .wr_done(wr_done), .rd_data(rd_data),
    .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .rd_start(rd_start), .wr_start(wr_start),
    .start_addr(start_addr), .start_wdata(start_wdata),
    .sram(sram)
  );

  sram_read_seq #(
    .ADDR_BITS(ADDR_BITS),
    .DATA_BITS(DATA_BITS),
    .T_AA_CYC(T_AA_CYC)
  ) rd_seq0 (
    .oe_n(oe_n), .rst_n(rst_n), .start(rd_start), .addr(start_addr),
    .sram_rdata(sram_rdata), .pins(rd_pins), .rdata(rd_data),
    .done(rd_done), .busy(rd_busy)
  );

  sram_write_seq #(
    .ADDR_BITS(ADDR_BITS),
    .DATA_BITS(DATA_BITS),
    .T_AW_CYC(T_AW_CYC)
  ) wr_seq0 (
    .oe_n(oe_n), .rst_n(rst_n), .start(wr_start), .addr(start_addr),
    .wdata(start_wdata), .pins(wr_pins), .done(wr_done), .busy(wr_busy)
  );

endmodule

// ==== hdl/sram_bus_arbiter.sv ====
`timescale 1ns/1ns

module sram_bus_arbiter #(
  parameter int ADDR_BITS = 10,
  parameter int DATA_BITS = 16
) (
  input  logic                      oe_n,
  input  logic                      rst_n,
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  logic [31:0]               paddr,
  input  logic [DATA_BITS-1:0]      pwdata,
  input  sram_ctrl_pkg::sram_pins_t rd_pins,
  input  sram_ctrl_pkg::sram_pins_t wr_pins,
  input  logic                      rd_busy,
  input  logic                      wr_busy,
  input  logic                      rd_done,
  input  logic                      wr_done,
  input  logic [DATA_BITS-1:0]      rd_data,
  output logic [DATA_BITS-1:0]      prdata,
  output logic                      pready,
  output logic                      pslverr,
  output logic                      rd_start,
  output logic                      wr_start,
  output logic [ADDR_BITS-1:0]      start_addr,
  output logic [DATA_BITS-1:0]      start_wdata,
  output sram_ctrl_pkg::sram_pins_t sram
);

  sram_ctrl_pkg::apb_op_t    op;
  sram_ctrl_pkg::sram_pins_t pins_sel;
  logic                      xfer_active;
  logic                      pready_q;
  logic                      first_acc;

  // First access cycle, not yet started and not just answered
  assign first_acc = psel && penable && !xfer_active && !pready_q;

  always_comb begin
    op = sram_ctrl_pkg::op_none;
    if (first_acc) begin
      if (paddr[31:ADDR_BITS] != '0) begin
        op = sram_ctrl_pkg::op_error;
      end else if (pwrite) begin
        op = sram_ctrl_pkg::op_write;
      end else begin
        op = sram_ctrl_pkg::op_read;
      end
    end
  end

  assign rd_start    = (op == sram_ctrl_pkg::op_read);
  assign wr_start    = (op == sram_ctrl_pkg::op_write);
  assign start_addr  = paddr[ADDR_BITS-1:0];
  assign start_wdata = pwdata;

  // Out of range answers at once, others one cycle after done
  assign pready  = pready_q || (op == sram_ctrl_pkg::op_error);
  assign pslverr = (op == sram_ctrl_pkg::op_error);

  // Starting sequencer owns the pins from its start cycle on
  always_comb begin
    if (rd_start || rd_busy) begin
      pins_sel = rd_pins;
    end else if (wr_start || wr_busy) begin
      pins_sel = wr_pins;
    end else begin
      pins_sel = sram_ctrl_pkg::SRAM_PINS_IDLE;
    end
  end

  always_ff @(posedge oe_n) begin
    if (!rst_n) begin
      sram        <= sram_ctrl_pkg::SRAM_PINS_IDLE;
      xfer_active <= 1'b0;
      pready_q    <= 1'b0;
    end else begin
      sram        <= pins_sel;
      pready_q    <= rd_done || wr_done;
      if (rd_start || wr_start) begin
        xfer_active <= 1'b1;
      end else if (rd_done || wr_done) begin
        xfer_active <= 1'b0;
      end
    end
  end

  // Read word held for the pready cycle
  always_ff @(posedge oe_n) begin
    if (rd_done) begin
      prdata <= rd_data;
    end
  end

  // One outstanding APB transfer means one sequencer at a time
  a_one_busy: assert property (@(posedge oe_n) disable iff (!rst_n)
    !(rd_busy && wr_busy))
    else $error("read and write sequencers busy together");

endmodule

// ==== hdl/sram_write_seq.sv ====
`timescale 1ns/1ns

module sram_write_seq #(
  parameter int ADDR_BITS = 10,
  parameter int DATA_BITS = 16,
  parameter int T_AW_CYC  = 2
) (
  input  logic                      oe_n,
  input  logic                      rst_n,
  input  logic                      start,
  input  logic [ADDR_BITS-1:0]      addr,
  input  logic [DATA_BITS-1:0]      wdata,
  output sram_ctrl_pkg::sram_pins_t pins,
  output logic                      done,
  output logic                      busy
);

  localparam int CNT_W = $clog2(T_AW_CYC + 1);

  sram_ctrl_pkg::seq_state_t state;
  sram_ctrl_pkg::seq_state_t state_nxt;
  logic [CNT_W-1:0]          cnt;
  logic [ADDR_BITS-1:0]      addr_q;
  logic [ADDR_BITS-1:0]      addr_nxt;
  logic [DATA_BITS-1:0]      wdata_q;
  logic [DATA_BITS-1:0]      wdata_nxt;
  logic                      last_cyc;

  // Last cycle of the we_n pulse
  assign last_cyc = (cnt == CNT_W'(T_AW_CYC - 1));

  always_comb begin
    state_nxt = state;
    case (state)
      sram_ctrl_pkg::idle: begin
        if (start) begin
          state_nxt = sram_ctrl_pkg::setup;
        end
      end
      sram_ctrl_pkg::setup:  state_nxt = sram_ctrl_pkg::active;
      sram_ctrl_pkg::active: begin
        if (last_cyc) begin
          state_nxt = sram_ctrl_pkg::finish;
        end
      end
      default: state_nxt = sram_ctrl_pkg::idle;
    endcase
  end

  // Address and data captured on start
  assign addr_nxt  = start ? addr : addr_q;
  assign wdata_nxt = start ? wdata : wdata_q;

  always_ff @(posedge oe_n) begin
    if (!rst_n) begin
      state <= sram_ctrl_pkg::idle;
      cnt   <= '0;
    end else begin
      state <= state_nxt;
      cnt   <= (state == sram_ctrl_pkg::active) ? cnt + 1'b1 : '0;
    end
  end

  always_ff @(posedge oe_n) begin
    addr_q  <= addr_nxt;
    wdata_q <= wdata_nxt;
  end

  // Finish keeps ce, address and data
  // we_n rises into the finish cycle
  always_comb begin
    pins                       = sram_ctrl_pkg::SRAM_PINS_IDLE;
    pins.addr[ADDR_BITS-1:0]   = addr_nxt;
    pins.wdata[DATA_BITS-1:0]  = wdata_nxt;
    pins.ce_n                  = (state_nxt == sram_ctrl_pkg::idle);
    pins.we_n                  = (state_nxt != sram_ctrl_pkg::active);
    pins.data_oe               = (state_nxt != sram_ctrl_pkg::idle);
  end

  assign done = (state == sram_ctrl_pkg::finish);
  assign busy = (state != sram_ctrl_pkg::idle);

  // A pulse in progress keeps the chip selected and is never restarted
  a_we_in_ce: assert property (@(posedge oe_n) disable iff (!rst_n)
    !pins.we_n |-> !pins.ce_n && !start)
    else $error("we_n low without chip select or with a new start");

endmodule

// ==== hdl/sram_read_seq.sv ====
`timescale 1ns/1ns

module sram_read_seq #(
  parameter int ADDR_BITS = 10,
  parameter int DATA_BITS = 16,
  parameter int T_AA_CYC  = 3
) (
  input  logic                      oe_n,
  input  logic                      rst_n,
  input  logic                      start,
  input  logic [ADDR_BITS-1:0]      addr,
  input  logic [DATA_BITS-1:0]      sram_rdata,
  output sram_ctrl_pkg::sram_pins_t pins,
  output logic [DATA_BITS-1:0]      rdata,
  output logic                      done,
  output logic                      busy
);

  localparam int CNT_W = $clog2(T_AA_CYC + 1);

  sram_ctrl_pkg::seq_state_t state;
  sram_ctrl_pkg::seq_state_t state_nxt;
  logic [CNT_W-1:0]          cnt;
  logic [ADDR_BITS-1:0]      addr_q;
  logic [ADDR_BITS-1:0]      addr_nxt;
  logic                      last_cyc;

  // Final cycle of the access window
  assign last_cyc = (cnt == CNT_W'(T_AA_CYC - 1));

  always_comb begin
    state_nxt = state;
    case (state)
      sram_ctrl_pkg::idle: begin
        if (start) begin
          state_nxt = sram_ctrl_pkg::setup;
        end
      end
      sram_ctrl_pkg::setup:  state_nxt = sram_ctrl_pkg::active;
      sram_ctrl_pkg::active: begin
        if (last_cyc) begin
          state_nxt = sram_ctrl_pkg::finish;
        end
      end
      default: state_nxt = sram_ctrl_pkg::idle;
    endcase
  end

  // Address latched on start, held for the whole access
  assign addr_nxt = start ? addr : addr_q;

  always_ff @(posedge oe_n) begin
    if (!rst_n) begin
      state <= sram_ctrl_pkg::idle;
      cnt   <= '0;
    end else begin
      state <= state_nxt;
      // Counts cycles with sram_oe_n low
      cnt   <= (state == sram_ctrl_pkg::active) ? cnt + 1'b1 : '0;
    end
  end

  always_ff @(posedge oe_n) begin
    addr_q <= addr_nxt;
    // Sample the bus at the end of the last access cycle
    if (state == sram_ctrl_pkg::active && last_cyc) begin
      rdata <= sram_rdata;
    end
  end

  // Pin request for the next cycle, the arbiter registers it
  always_comb begin
    pins                      = sram_ctrl_pkg::SRAM_PINS_IDLE;
    pins.addr[ADDR_BITS-1:0]  = addr_nxt;
    pins.ce_n                 = (state_nxt == sram_ctrl_pkg::idle);
    pins.sram_oe_n            = (state_nxt != sram_ctrl_pkg::active);
  end

  assign done = (state == sram_ctrl_pkg::finish);
  assign busy = (state != sram_ctrl_pkg::idle);

  // Address must stay put from setup until the access ends
  a_addr_stable: assert property (@(posedge oe_n) disable iff (!rst_n)
    busy && $past(busy) |-> $stable(pins.addr))
    else $error("read address changed during access");

endmodule

// ==== hdl/sram_ctrl_pkg.sv ====
package sram_ctrl_pkg;

  // Upper bounds on the pin widths, modules use the low bits
  localparam int MAX_ADDR_BITS = 16;
  localparam int DATA_BITS_MAX = 32;

  // One bundle of SRAM pins as driven by the controller
  // Enables are active low, data_oe takes the place of a tri-state driver
  typedef struct packed {
    logic                     ce_n;
    logic                     sram_oe_n;
    logic                     we_n;
    logic [MAX_ADDR_BITS-1:0] addr;
    logic [DATA_BITS_MAX-1:0] wdata;
    logic                     data_oe;
  } sram_pins_t;

  // Pins with the chip deselected and the data bus released
  localparam sram_pins_t SRAM_PINS_IDLE = '{
    ce_n:      1'b1,
    sram_oe_n: 1'b1,
    we_n:      1'b1,
    addr:      '0,
    wdata:     '0,
    data_oe:   1'b0
  };

  // Steps of one SRAM access
  // Setup drives address and ce, active holds the strobe,
  // finish is the capture or hold cycle
  typedef enum logic [1:0] {
    idle,
    setup,
    active,
    finish
  } seq_state_t;

  // Decoded kind of an APB transfer
  typedef enum logic [1:0] {
    op_none,
    op_read,
    op_write,
    // Address outside the SRAM
    op_error
  } apb_op_t;

endpackage
